/* Makefile */
# Verilator build, run, lint and clean for the AES-128 encryptor.

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f filelist.f --top-module aesEncryptTb \
		--Mdir obj_dir -o aesEncryptTb

run: build
	@out="$$(./obj_dir/aesEncryptTb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTBENCH PASSED"

lint:
	verilator --lint-only --timing -f filelist.f --top-module aesEncryptTb

clean:
	rm -rf obj_dir

/* filelist.f */
logic/aesPkg.sv
logic/aesSboxWord.sv
logic/aesKeyExpand.sv
logic/aesRoundDatapath.sv
logic/aesCommandDecode.sv
logic/aesResultStage.sv
logic/aesEncryptTop.sv
sim/aesEncryptTb.sv

/* logic/aesCommandDecode.sv */
// AES command and round controller turning strobes and enable into per-cycle control.
module aesCommandDecode
  import aesPkg::*;
(
  input  logic      CLK,
  input  logic      RST,
  input  logic      en,
  input  logic      keyRdy,
  input  logic      dataRdy,
  output logic      busy,
  output roundCtrlT ctrl
);

  ctrlStateT stateQ;
  roundT     roundQ;
  roundT     roundRot;

  assign roundRot = {roundQ[NumRounds-2:0], roundQ[NumRounds-1]};
  assign busy     = (stateQ == Run);

  // ********************
  // Control decode
  // ********************
  always_comb begin
    ctrl           = '0;
    ctrl.round     = roundQ;
    ctrl.lastRound = (stateQ == Run) && roundQ[0];  // Round register has wrapped.
    if (en) begin
      if (stateQ == Idle) begin
        ctrl.loadKey = keyRdy;
        ctrl.start   = !keyRdy && dataRdy;  // Key load wins.
      end else begin
        ctrl.step = 1'b1;
      end
    end
  end

  // ********************
  // State and round
  // ********************
  always_ff @(posedge CLK) begin
    if (!RST) begin
      stateQ <= Idle;
      roundQ <= FirstRound;
    end else if (ctrl.start) begin
      stateQ <= Run;
      roundQ <= roundRot;
    end else if (ctrl.step) begin
      if (ctrl.lastRound) begin
        stateQ <= Idle;
        roundQ <= FirstRound;
      end else begin
        roundQ <= roundRot;
      end
    end
  end

  // ********************
  // Assertions
  // ********************
  roundOneHot: assert property (@(posedge CLK) disable iff (!RST) $onehot(roundQ));

  // A block in flight stays in Run until its final step.
  noStartInRun: assert property (
    @(posedge CLK) disable iff (!RST)
    (busy && !(ctrl.step && ctrl.lastRound)) |=> !ctrl.start);

  noStepInIdle: assert property (
    @(posedge CLK) disable iff (!RST)
    ((!busy && !ctrl.start) || (ctrl.step && ctrl.lastRound)) |=> !ctrl.step);

endmodule

/* logic/aesEncryptTop.sv */
// Iterative AES-128 encryptor top level joining controller, round datapath and result stage.
module aesEncryptTop
  import aesPkg::*;
(
  input  logic  CLK,
  input  logic  RST,
  input  logic  en,
  input  logic  keyRdy,
  input  logic  dataRdy,
  input  blockT key,
  input  blockT din,
  output blockT dout,
  output logic  busy,
  output logic  dataValid
);

  roundCtrlT ctrl;
  blockT     nextState;

  aesCommandDecode cmdDecode (
    .CLK    (CLK),
    .RST    (RST),
    .en     (en),
    .keyRdy (keyRdy),
    .dataRdy(dataRdy),
    .busy   (busy),
    .ctrl   (ctrl)
  );

  aesRoundDatapath roundPath (
    .CLK      (CLK),
    .ctrl     (ctrl),
    .key      (key),
    .din      (din),
    .nextState(nextState)
  );

  aesResultStage resultStage (
    .CLK      (CLK),
    .RST      (RST),
    .ctrl     (ctrl),
    .nextState(nextState),
    .dout     (dout),
    .dataValid(dataValid)
  );

endmodule

/* logic/aesKeyExpand.sv */
// AES-128 forward key schedule step deriving the next round key from the current one.
module aesKeyExpand
  import aesPkg::*;
(
  input  blockT roundKey,
  input  roundT round,
  output blockT nextKey
);

  wordT w0, w1, w2, w3;
  wordT subRot;
  wordT n0, n1, n2, n3;

  assign {w0, w1, w2, w3} = roundKey;

  // ********************
  // RotWord and SubWord
  // ********************
  aesSboxWord subWord (
    .x({w3[23:0], w3[31:24]}),  // One byte left rotation.
    .y(subRot)
  );

  // ********************
  // Word chain
  // ********************
  assign n0 = w0 ^ subRot ^ {rconOf(round), 24'h000000};
  assign n1 = w1 ^ n0;
  assign n2 = w2 ^ n1;
  assign n3 = w3 ^ n2;

  assign nextKey = {n0, n1, n2, n3};

endmodule

/* logic/aesPkg.sv */
// AES package holding the block widths, round count, GF(2^8) helpers and controller types.
package aesPkg;

  // ********************
  // Sizes
  // ********************
  localparam int NumRounds  = 10;
  localparam int ByteWidth  = 8;
  localparam int WordWidth  = 32;
  localparam int BlockWidth = 128;
  localparam int NumRows    = WordWidth / ByteWidth;   // Bytes per column.
  localparam int NumCols    = BlockWidth / WordWidth;  // Columns per block.

  typedef logic [BlockWidth-1:0] blockT;  // Byte 0 sits in the top bits.
  typedef logic [WordWidth-1:0]  wordT;
  typedef logic [ByteWidth-1:0]  byteT;
  typedef logic [NumRounds-1:0]  roundT;  // One-hot, bit 0 is round 1.

  localparam roundT FirstRound = roundT'(1);

  // ********************
  // Controller types
  // ********************
  typedef enum logic {
    Idle = 1'b0,
    Run  = 1'b1
  } ctrlStateT;

  typedef struct packed {
    logic  loadKey;    // Store the cipher key.
    logic  start;      // Take a plaintext and add the cipher key.
    logic  step;       // Perform one round.
    logic  lastRound;  // The round in progress is round 10.
    roundT round;
  } roundCtrlT;

  // ********************
  // GF(2^8) helpers
  // ********************
  function automatic byteT xtime(byteT b);
    return {b[ByteWidth-2:0], 1'b0} ^ (b[ByteWidth-1] ? 8'h1b : 8'h00);
  endfunction

  // The round constants are successive doublings of 01.
  function automatic byteT rconOf(roundT r);
    byteT rc;
    byteT acc;
    rc  = '0;
    acc = 8'h01;
    for (int i = 0; i < NumRounds; i++) begin
      if (r[i]) begin
        rc = acc;
      end
      acc = xtime(acc);
    end
    return rc;
  endfunction

endpackage

/* logic/aesResultStage.sv */
// AES result register holding the last ciphertext and its valid flag.
module aesResultStage
  import aesPkg::*;
(
  input  logic      CLK,
  input  logic      RST,
  input  roundCtrlT ctrl,
  input  blockT     nextState,
  output blockT     dout,
  output logic      dataValid
);

  logic capture;
  logic clear;

  assign capture = ctrl.step && ctrl.lastRound;
  assign clear   = ctrl.loadKey || ctrl.start;

  always_ff @(posedge CLK) begin
    if (!RST) begin
      dataValid <= 1'b0;
    end else if (capture) begin
      dataValid <= 1'b1;
    end else if (clear) begin
      dataValid <= 1'b0;  // Next command supersedes the result.
    end
  end

  always_ff @(posedge CLK) begin
    if (capture) begin
      dout <= nextState;  // Held while the next block runs.
    end
  end

  captureClearExclusive: assert property (
    @(posedge CLK) disable iff (!RST) !(capture && clear));

endmodule

/* logic/aesRoundDatapath.sv */
// AES-128 encryption round datapath with state, cipher key and working round key registers.
module aesRoundDatapath
  import aesPkg::*;
(
  input  logic      CLK,
  input  roundCtrlT ctrl,
  input  blockT     key,
  input  blockT     din,
  output blockT     nextState
);

  blockT stateQ;
  blockT cipherKeyQ;
  blockT workKeyQ;
  blockT expandedKey;

  blockT subBytes;
  blockT shifted;
  blockT mixed;

  byteT [0:NumRows*NumCols-1] subArr;
  byteT [0:NumRows*NumCols-1] shiftArr;

  // Column times the fixed MixColumns matrix {02 03 01 01}.
  function automatic wordT mixColumn(wordT col);
    byteT a0, a1, a2, a3;
    {a0, a1, a2, a3} = col;
    return {xtime(a0 ^ a1) ^ a1 ^ a2 ^ a3,
            a0 ^ xtime(a1 ^ a2) ^ a2 ^ a3,
            a0 ^ a1 ^ xtime(a2 ^ a3) ^ a3,
            xtime(a3 ^ a0) ^ a0 ^ a1 ^ a2};
  endfunction

  // ********************
  // Round function
  // ********************
  assign subArr  = subBytes;
  assign shifted = shiftArr;

  for (genvar c = 0; c < NumCols; c++) begin : colGen
    aesSboxWord subCol (
      .x(stateQ[BlockWidth-1-c*WordWidth -: WordWidth]),
      .y(subBytes[BlockWidth-1-c*WordWidth -: WordWidth])
    );

    for (genvar r = 0; r < NumRows; r++) begin : rowGen
      assign shiftArr[NumRows*c + r] = subArr[NumRows*((c + r) % NumCols) + r];  // Row r left by r.
    end

    assign mixed[BlockWidth-1-c*WordWidth -: WordWidth] =
      mixColumn(shifted[BlockWidth-1-c*WordWidth -: WordWidth]);
  end

  assign nextState = (ctrl.lastRound ? shifted : mixed) ^ workKeyQ;

  // ********************
  // Key schedule
  // ********************
  aesKeyExpand keyStep (
    .roundKey(workKeyQ),
    .round   (ctrl.round),
    .nextKey (expandedKey)
  );

  always_ff @(posedge CLK) begin
    if (ctrl.loadKey) begin
      cipherKeyQ <= key;
      workKeyQ   <= key;
    end else if (ctrl.start) begin
      stateQ   <= din ^ cipherKeyQ;  // Initial AddRoundKey.
      workKeyQ <= expandedKey;
    end else if (ctrl.step) begin
      stateQ <= nextState;
      if (ctrl.lastRound) begin
        workKeyQ <= cipherKeyQ;  // Ready for the next block under the same key.
      end else begin
        workKeyQ <= expandedKey;
      end
    end
  end

endmodule

/* logic/aesSboxWord.sv */
// Forward AES S-box applied to each of the four bytes of a word.
module aesSboxWord
  import aesPkg::*;
(
  input  wordT x,
  output wordT y
);

  // ********************
  // Byte lookup
  // ********************
  function automatic byteT subByte(byteT b);
    logic [256*ByteWidth-1:0] sboxTable;
    sboxTable = {
      128'h637c777bf26b6fc53001672bfed7ab76,
      128'hca82c97dfa5947f0add4a2af9ca472c0,
      128'hb7fd9326363ff7cc34a5e5f171d83115,
      128'h04c723c31896059a071280e2eb27b275,
      128'h09832c1a1b6e5aa0523bd6b329e32f84,
      128'h53d100ed20fcb15b6acbbe394a4c58cf,
      128'hd0efaafb434d338545f9027f503c9fa8,
      128'h51a3408f929d38f5bcb6da2110fff3d2,
      128'hcd0c13ec5f974417c4a77e3d645d1973,
      128'h60814fdc222a908846eeb814de5e0bdb,
      128'he0323a0a4906245cc2d3ac629195e479,
      128'he7c8376d8dd54ea96c56f4ea657aae08,
      128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
      128'h703eb5664803f60e613557b986c11d9e,
      128'he1f8981169d98e949b1e87e9ce5528df,
      128'h8ca1890dbfe6426841992d0fb054bb16
    };
    return sboxTable[(255 - int'(b)) * ByteWidth +: ByteWidth];  // Entry 0 is leftmost.
  endfunction

  assign y = {subByte(x[31:24]), subByte(x[23:16]), subByte(x[15:8]), subByte(x[7:0])};

endmodule

/* sim/aesEncryptTb.sv */
// AES-128 encryptor testbench driving FIPS-197 vectors, enable gaps and stray strobes.
module aesEncryptTb
  import aesPkg::*;
();

  // ********************
  // Constants
  // ********************
  localparam int    LatencyCycles = NumRounds + 1;  // Accept edge plus ten rounds.
  localparam int    TimeoutCycles = 400;            // Six tests of at most about 35 cycles, doubled.
  localparam int    MaxGapCycles  = 12;
  localparam int    StrayEdge     = 3;
  localparam int    RandomSeed    = 32'h0286_d781;

  localparam blockT FipsKey = 128'h000102030405060708090a0b0c0d0e0f;
  localparam blockT FipsPt  = 128'h00112233445566778899aabbccddeeff;
  localparam blockT FipsCt  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
  localparam blockT AppBKey = 128'h2b7e151628aed2a6abf7158809cf4f3c;
  localparam blockT AppBPt  = 128'h3243f6a8885a308d313198a2e0370734;
  localparam blockT AppBCt  = 128'h3925841d02dc09fbdc118597196a0b32;
  localparam blockT StrayKey = 128'hffeeddccbbaa99887766554433221100;

  logic  CLK;
  logic  RST;
  logic  en;
  logic  keyRdy;
  logic  dataRdy;
  blockT key;
  blockT din;
  blockT dout;
  logic  busy;
  logic  dataValid;

  int cycleCount      = 0;
  int errorCount      = 0;
  int testsRun        = 0;
  int testsFailed     = 0;
  int testStartErrors = 0;
  int latency;

  aesEncryptTop UUT (
    .CLK      (CLK),
    .RST      (RST),
    .en       (en),
    .keyRdy   (keyRdy),
    .dataRdy  (dataRdy),
    .key      (key),
    .din      (din),
    .dout     (dout),
    .busy     (busy),
    .dataValid(dataValid)
  );

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= TimeoutCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // ********************
  // Assertions
  // ********************
  resetClears: assert property (@(posedge CLK)
    (cycleCount > 0 && !$past(RST)) |-> (!busy && !dataValid))
    else begin
      errorCount++;
      $display("busy or dataValid was high during or right after reset");
    end

  acceptSetsBusy: assert property (@(posedge CLK) disable iff (!RST)
    (en && !busy && dataRdy && !keyRdy) |=> busy)
    else begin
      errorCount++;
      $display("an accepted dataRdy did not raise busy");
    end

  busyEndsWithResult: assert property (@(posedge CLK) disable iff (!RST)
    $fell(busy) == $rose(dataValid))
    else begin
      errorCount++;
      $display("busy fell and dataValid rose on different cycles");
    end

  commandClearsValid: assert property (@(posedge CLK) disable iff (!RST)
    (en && !busy && (keyRdy || dataRdy)) |=> !dataValid)
    else begin
      errorCount++;
      $display("dataValid stayed high after an accepted strobe");
    end

  keyWins: assert property (@(posedge CLK) disable iff (!RST)
    (en && !busy && keyRdy) |=> !busy)
    else begin
      errorCount++;
      $display("a key load started a block");
    end

  enableFreeze: assert property (@(posedge CLK) disable iff (!RST)
    !en |=> ($stable(busy) && $stable(dataValid) && $stable(dout)))
    else begin
      errorCount++;
      $display("an output changed in a cycle with en low");
    end

  // ********************
  // Helper tasks
  // ********************
  task automatic sendKey(input blockT k);
    key    = k;
    keyRdy = 1'b1;
    @(negedge CLK);
    keyRdy = 1'b0;
  endtask

  // Counts enabled edges from the accept edge until dataValid shows.
  task automatic runBlock(input blockT pt, input bit useGaps, input bit injectStrobes,
                          input blockT strayKey, output int enabledCycles);
    int gapLeft;
    int gapBudget;
    int edges;
    bit done;
    gapLeft       = 0;
    gapBudget     = useGaps ? MaxGapCycles : 0;
    edges         = 0;
    done          = 1'b0;
    enabledCycles = 0;
    din     = pt;
    dataRdy = 1'b1;
    en      = 1'b1;
    while (!done) begin
      @(negedge CLK);
      edges++;
      if (en) begin
        enabledCycles++;
      end
      dataRdy = 1'b0;
      keyRdy  = 1'b0;
      if (dataValid) begin
        done = 1'b1;
        en   = 1'b1;
      end else begin
        assert (busy) else begin
          errorCount++;
          $display("busy dropped before the ciphertext was ready");
        end
        if (injectStrobes && edges == StrayEdge) begin
          key     = strayKey;  // Both strobes land while busy.
          keyRdy  = 1'b1;
          dataRdy = 1'b1;
        end
        if (gapLeft == 0 && gapBudget > 0 && (edges == 1 || ($urandom % 3) == 0)) begin
          gapLeft = 1 + int'($urandom % 4);
          if (gapLeft > gapBudget) begin
            gapLeft = gapBudget;
          end
          gapBudget -= gapLeft;
        end
        if (gapLeft > 0) begin
          en = 1'b0;
          gapLeft--;
        end else begin
          en = 1'b1;
        end
      end
    end
  endtask

  task automatic checkDout(input blockT expected);
    assert (dout === expected) else begin
      errorCount++;
      $display("Error dout: expected %h, got %h", expected, dout);
    end
  endtask

  task automatic checkLatency(input int expected, input int actual);
    assert (actual == expected) else begin
      errorCount++;
      $display("Error latency: expected %h, got %h", expected, actual);
    end
  endtask

  task automatic finishTest(input string name);
    int errs;
    errs = errorCount - testStartErrors;
    testsRun++;
    if (errs == 0) begin
      $display("Test %0d %s: ok", testsRun, name);
    end else begin
      testsFailed++;
      $display("Test %0d %s: %0d errors", testsRun, name, errs);
    end
    testStartErrors = errorCount;
  endtask

  // ********************
  // Test sequence
  // ********************
  initial begin
    void'($urandom(RandomSeed));
    RST     = 1'b0;
    en      = 1'b1;
    keyRdy  = 1'b0;
    dataRdy = 1'b0;
    key     = '0;
    din     = '0;
    repeat (4) @(negedge CLK);
    RST = 1'b1;
    @(negedge CLK);
    finishTest("reset");

    sendKey(FipsKey);
    runBlock(FipsPt, 1'b0, 1'b0, '0, latency);
    checkDout(FipsCt);
    checkLatency(LatencyCycles, latency);
    finishTest("appendix C.1 vector");

    runBlock(FipsPt, 1'b0, 1'b0, '0, latency);  // Same key, no new keyRdy.
    checkDout(FipsCt);
    checkLatency(LatencyCycles, latency);
    finishTest("key retention");

    sendKey(AppBKey);
    runBlock(AppBPt, 1'b0, 1'b0, '0, latency);
    checkDout(AppBCt);
    checkLatency(LatencyCycles, latency);
    finishTest("appendix B vector");

    runBlock(AppBPt, 1'b1, 1'b0, '0, latency);
    checkDout(AppBCt);
    checkLatency(LatencyCycles, latency);
    finishTest("enable freeze");

    runBlock(AppBPt, 1'b0, 1'b1, StrayKey, latency);
    checkDout(AppBCt);
    checkLatency(LatencyCycles, latency);
    key     = FipsKey;
    din     = AppBPt;
    keyRdy  = 1'b1;
    dataRdy = 1'b1;
    @(negedge CLK);
    keyRdy  = 1'b0;
    dataRdy = 1'b0;
    assert (!busy && !dataValid) else begin
      errorCount++;
      $display("both strobes in one idle cycle did not load the key");
    end
    runBlock(FipsPt, 1'b0, 1'b0, '0, latency);
    checkDout(FipsCt);
    checkLatency(LatencyCycles, latency);
    finishTest("ignored strobes");

    repeat (2) @(negedge CLK);
    $display("Tests run: %0d, failed: %0d, errors: %0d", testsRun, testsFailed, errorCount);
    if (errorCount == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule
